//--- verilog/thumb_decode_pkg.sv
`default_nettype none

package thumb_decode_pkg;

    localparam int WORD      = 32;
    localparam int HALF_WORD = 16;
    // four bits so the stack pointer fits in a register field
    localparam int REG_W     = 4;

    localparam logic [REG_W-1:0] SP_REG = 4'd13;

    typedef logic [HALF_WORD-1:0] instruction;

    typedef enum logic [3:0] {
        SHIFT_IMM       = 4'd0,
        ARITH_IMM8      = 4'd1,
        DATA_PROCESSING = 4'd2,
        LOAD_STORE_IMM  = 4'd3,
        LOAD_STORE_BYTE = 4'd4,
        LOAD_STORE_HW   = 4'd5,
        LOAD_STORE_SP_R = 4'd6,
        MISC_SP_ADJ     = 4'd7,
        BL_PREFIX       = 4'd8,
        BL_SUFFIX       = 4'd9,
        ILLEGAL         = 4'd10
    } instr_class;

    // sub-operation codes, meaning depends on the class
    localparam logic [2:0] SOP_NONE     = 3'd0;

    // SHIFT_IMM family
    localparam logic [2:0] SOP_LSL      = 3'd0;
    localparam logic [2:0] SOP_LSR      = 3'd1;
    localparam logic [2:0] SOP_ASR      = 3'd2;
    localparam logic [2:0] SOP_ADD_REG  = 3'd3;
    localparam logic [2:0] SOP_SUB_REG  = 3'd4;
    localparam logic [2:0] SOP_ADD_IMM3 = 3'd5;
    localparam logic [2:0] SOP_SUB_IMM3 = 3'd6;

    // ARITH_IMM8 family
    localparam logic [2:0] SOP_MOV      = 3'd0;
    localparam logic [2:0] SOP_CMP      = 3'd1;
    localparam logic [2:0] SOP_ADD8     = 3'd2;
    localparam logic [2:0] SOP_SUB8     = 3'd3;

    // DATA_PROCESSING, only reverse-subtract is told apart
    localparam logic [2:0] SOP_ALU      = 3'd0;
    localparam logic [2:0] SOP_RSB      = 3'd1;
    localparam logic [3:0] DP_RSB_OP    = 4'b1001;

    // load/store direction
    localparam logic [2:0] SOP_STORE    = 3'd0;
    localparam logic [2:0] SOP_LOAD     = 3'd1;

    // stack pointer adjust direction
    localparam logic [2:0] SOP_SP_ADD   = 3'd0;
    localparam logic [2:0] SOP_SP_SUB   = 3'd1;

    typedef struct packed {
        instr_class cls;
        logic [2:0] sub_op;
    } class_info;

    typedef struct packed {
        instr_class       cls;
        logic [REG_W-1:0] rd;
        logic [REG_W-1:0] rn;
        logic [REG_W-1:0] rm;
        logic [WORD-1:0]  imm;
        logic             imm_valid;
        logic             bl_complete;
        logic             illegal;
    } decoded_instr;

endpackage

`default_nettype wire

//--- verilog/instr_classify.sv
`timescale 1ns/10ps
`default_nettype none

module instr_classify (
    input  thumb_decode_pkg::instruction instr_i,
    output thumb_decode_pkg::class_info  class_o
);
    import thumb_decode_pkg::*;

    always_comb begin
        class_o.cls    = ILLEGAL;
        class_o.sub_op = SOP_NONE;

        casez (instr_i[15:11])
            5'b000??: begin
                class_o.cls = SHIFT_IMM;
                case (instr_i[12:11])
                    2'b00: class_o.sub_op = SOP_LSL;
                    2'b01: class_o.sub_op = SOP_LSR;
                    2'b10: class_o.sub_op = SOP_ASR;
                    default: begin
                        // bit 10 picks immediate vs register, bit 9 picks subtract
                        case ({instr_i[10], instr_i[9]})
                            2'b00:   class_o.sub_op = SOP_ADD_REG;
                            2'b01:   class_o.sub_op = SOP_SUB_REG;
                            2'b10:   class_o.sub_op = SOP_ADD_IMM3;
                            default: class_o.sub_op = SOP_SUB_IMM3;
                        endcase
                    end
                endcase
            end

            5'b001??: begin
                class_o.cls = ARITH_IMM8;
                case (instr_i[12:11])
                    2'b00:   class_o.sub_op = SOP_MOV;
                    2'b01:   class_o.sub_op = SOP_CMP;
                    2'b10:   class_o.sub_op = SOP_ADD8;
                    default: class_o.sub_op = SOP_SUB8;
                endcase
            end

            5'b01000: begin
                // 010001 is the hi-register group, not decoded here
                if (!instr_i[10]) begin
                    class_o.cls    = DATA_PROCESSING;
                    class_o.sub_op = (instr_i[9:6] == DP_RSB_OP) ? SOP_RSB : SOP_ALU;
                end
            end

            5'b0110?: begin
                class_o.cls    = LOAD_STORE_IMM;
                class_o.sub_op = instr_i[11] ? SOP_LOAD : SOP_STORE;
            end

            5'b0111?: begin
                class_o.cls    = LOAD_STORE_BYTE;
                class_o.sub_op = instr_i[11] ? SOP_LOAD : SOP_STORE;
            end

            5'b1000?: begin
                class_o.cls    = LOAD_STORE_HW;
                class_o.sub_op = instr_i[11] ? SOP_LOAD : SOP_STORE;
            end

            5'b1001?: begin
                class_o.cls    = LOAD_STORE_SP_R;
                class_o.sub_op = instr_i[11] ? SOP_LOAD : SOP_STORE;
            end

            5'b10110: begin
                // only 1011_0000 is the sp adjust, rest of misc stays illegal
                if (instr_i[10:8] == 3'b000) begin
                    class_o.cls    = MISC_SP_ADJ;
                    class_o.sub_op = instr_i[7] ? SOP_SP_SUB : SOP_SP_ADD;
                end
            end

            5'b11110: class_o.cls = BL_PREFIX;
            5'b11111: class_o.cls = BL_SUFFIX;

            default: begin
                class_o.cls    = ILLEGAL;
                class_o.sub_op = SOP_NONE;
            end
        endcase
    end

    // no clock here, so the check runs on every change of the halfword
    always_comb begin
        if (!$isunknown(instr_i)) begin
            assert (!$isunknown(class_o))
                else $error("instr_classify: unknown class for halfword %h", instr_i);
        end
    end

endmodule

`default_nettype wire

//--- verilog/imm_gen.sv
`timescale 1ns/10ps
`default_nettype none

module imm_gen (
    input  logic                              clk_i,
    input  logic                              reset_i,
    input  logic                              instr_valid_i,
    input  thumb_decode_pkg::instruction      instr_i,
    input  thumb_decode_pkg::class_info       class_i,
    output logic [thumb_decode_pkg::WORD-1:0] imm_o,
    output logic                              imm_valid_o
);
    import thumb_decode_pkg::*;

    // branch-with-link offset: 11 prefix bits, 11 suffix bits, low zero
    localparam int BL_OFF_W = 23;

    instruction          prev_instr_q;
    logic [BL_OFF_W-1:0] bl_off;

    // last valid halfword, holds the prefix while a suffix is awaited
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            prev_instr_q <= '0;
        end else if (instr_valid_i) begin
            prev_instr_q <= instr_i;
        end
    end

    assign bl_off = {prev_instr_q[10:0], instr_i[10:0], 1'b0};

    always_comb begin
        imm_o       = '0;
        imm_valid_o = 1'b1;

        case (class_i.cls)
            SHIFT_IMM: begin
                case (class_i.sub_op)
                    SOP_LSL, SOP_LSR, SOP_ASR: begin
                        imm_o = WORD'(instr_i[10:6]);
                    end
                    SOP_ADD_IMM3, SOP_SUB_IMM3: begin
                        imm_o = WORD'(instr_i[8:6]);
                    end
                    default: begin
                        // register add/sub, operand comes from rm
                        imm_valid_o = 1'b0;
                    end
                endcase
            end

            ARITH_IMM8: imm_o = WORD'(instr_i[7:0]);

            DATA_PROCESSING: begin
                // rsb is the only alu op with an implied #0
                imm_valid_o = (class_i.sub_op == SOP_RSB);
            end

            // word offsets scaled by 4
            LOAD_STORE_IMM:  imm_o = WORD'({instr_i[10:6], 2'b00});
            LOAD_STORE_BYTE: imm_o = WORD'(instr_i[10:6]);
            // halfword offsets scaled by 2
            LOAD_STORE_HW:   imm_o = WORD'({instr_i[10:6], 1'b0});
            LOAD_STORE_SP_R: imm_o = WORD'({instr_i[7:0], 2'b00});
            MISC_SP_ADJ:     imm_o = WORD'({instr_i[6:0], 2'b00});

            BL_SUFFIX: begin
                // sign taken from the top bit of the saved prefix field
                imm_o = {{(WORD-BL_OFF_W){bl_off[BL_OFF_W-1]}}, bl_off};
            end

            default: begin
                // BL_PREFIX and ILLEGAL carry nothing usable on their own
                imm_valid_o = 1'b0;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- verilog/reg_field_decode.sv
`timescale 1ns/10ps
`default_nettype none

module reg_field_decode (
    input  thumb_decode_pkg::instruction       instr_i,
    input  thumb_decode_pkg::class_info        class_i,
    output logic [thumb_decode_pkg::REG_W-1:0] rd_o,
    output logic [thumb_decode_pkg::REG_W-1:0] rn_o,
    output logic [thumb_decode_pkg::REG_W-1:0] rm_o
);
    import thumb_decode_pkg::*;

    // low registers only in 16-bit fields
    function automatic logic [REG_W-1:0] low_reg(input logic [2:0] field);
        return {{(REG_W-3){1'b0}}, field};
    endfunction

    always_comb begin
        rd_o = '0;
        rn_o = '0;
        rm_o = '0;

        case (class_i.cls)
            SHIFT_IMM: begin
                rd_o = low_reg(instr_i[2:0]);
                rn_o = low_reg(instr_i[5:3]);
                // only the register add/sub forms have a second operand register
                if (class_i.sub_op == SOP_ADD_REG || class_i.sub_op == SOP_SUB_REG) begin
                    rm_o = low_reg(instr_i[8:6]);
                end
            end

            ARITH_IMM8: begin
                rd_o = low_reg(instr_i[10:8]);
                // mov has no first operand
                if (class_i.sub_op != SOP_MOV) begin
                    rn_o = low_reg(instr_i[10:8]);
                end
            end

            DATA_PROCESSING: begin
                rd_o = low_reg(instr_i[2:0]);
                if (class_i.sub_op == SOP_RSB) begin
                    rn_o = low_reg(instr_i[5:3]);
                end else begin
                    // two-operand form, rd doubles as rn
                    rn_o = low_reg(instr_i[2:0]);
                    rm_o = low_reg(instr_i[5:3]);
                end
            end

            LOAD_STORE_IMM, LOAD_STORE_BYTE, LOAD_STORE_HW: begin
                rd_o = low_reg(instr_i[2:0]);
                rn_o = low_reg(instr_i[5:3]);
            end

            LOAD_STORE_SP_R: begin
                rd_o = low_reg(instr_i[10:8]);
                rn_o = SP_REG;
            end

            MISC_SP_ADJ: begin
                rd_o = SP_REG;
                rn_o = SP_REG;
            end

            default: begin
                rd_o = '0;
                rn_o = '0;
                rm_o = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- verilog/bl_pair_tracker.sv
`timescale 1ns/10ps
`default_nettype none

module bl_pair_tracker (
    input  logic                        clk_i,
    input  logic                        reset_i,
    input  logic                        instr_valid_i,
    input  thumb_decode_pkg::class_info class_i,
    output logic                        bl_complete_o,
    output logic                        orphan_o
);
    import thumb_decode_pkg::*;

    logic pending_q;
    logic is_prefix;
    logic is_suffix;

    assign is_prefix = instr_valid_i && (class_i.cls == BL_PREFIX);
    assign is_suffix = instr_valid_i && (class_i.cls == BL_SUFFIX);

    // idle cycles keep the flag, any other valid halfword drops it
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            pending_q <= 1'b0;
        end else if (instr_valid_i) begin
            pending_q <= is_prefix;
        end
    end

    assign bl_complete_o = is_suffix && pending_q;
    assign orphan_o      = is_suffix && !pending_q;

    a_pair_exclusive: assert property (
        @(posedge clk_i) disable iff (reset_i)
        !(bl_complete_o && orphan_o)
    ) else $error("bl_pair_tracker: complete and orphan both high");

endmodule

`default_nettype wire

//--- verilog/thumb_decode_top.sv
`timescale 1ns/10ps
`default_nettype none

module thumb_decode_top (
    input  logic                           clk_i,
    input  logic                           reset_i,
    input  thumb_decode_pkg::instruction   instr_i,
    input  logic                           instr_valid_i,
    output thumb_decode_pkg::decoded_instr decoded_o,
    output logic                           decoded_valid_o
);
    import thumb_decode_pkg::*;

    class_info        class_w;
    logic [WORD-1:0]  imm_w;
    logic             imm_valid_w;
    logic [REG_W-1:0] rd_w;
    logic [REG_W-1:0] rn_w;
    logic [REG_W-1:0] rm_w;
    logic             bl_complete_w;
    logic             orphan_w;

    instr_classify instr_classify_i (
        .instr_i (instr_i),
        .class_o (class_w)
    );

    imm_gen imm_gen_i (
        .clk_i         (clk_i),
        .reset_i       (reset_i),
        .instr_valid_i (instr_valid_i),
        .instr_i       (instr_i),
        .class_i       (class_w),
        .imm_o         (imm_w),
        .imm_valid_o   (imm_valid_w)
    );

    reg_field_decode reg_field_decode_i (
        .instr_i (instr_i),
        .class_i (class_w),
        .rd_o    (rd_w),
        .rn_o    (rn_w),
        .rm_o    (rm_w)
    );

    bl_pair_tracker bl_pair_tracker_i (
        .clk_i         (clk_i),
        .reset_i       (reset_i),
        .instr_valid_i (instr_valid_i),
        .class_i       (class_w),
        .bl_complete_o (bl_complete_w),
        .orphan_o      (orphan_w)
    );

    // same-cycle decode, nothing registered on the output side
    assign decoded_o.cls         = class_w.cls;
    assign decoded_o.rd          = rd_w;
    assign decoded_o.rn          = rn_w;
    assign decoded_o.rm          = rm_w;
    assign decoded_o.imm         = imm_w;
    assign decoded_o.imm_valid   = imm_valid_w;
    assign decoded_o.bl_complete = bl_complete_w;
    // an unpaired suffix is as bad as an unassigned encoding
    assign decoded_o.illegal     = (class_w.cls == ILLEGAL) || orphan_w;

    assign decoded_valid_o = instr_valid_i;

endmodule

`default_nettype wire

//--- tb/tb_thumb_decode.sv
`timescale 1ns/10ps
`default_nettype none

module tb_thumb_decode;
    import thumb_decode_pkg::*;

    logic         clk_i;
    logic         reset_i;
    instruction   instr_i;
    logic         instr_valid_i;
    decoded_instr decoded_o;
    logic         decoded_valid_o;

    integer seed   = 32'hdf94_ac44;
    int     errors = 0;
    int     checks = 0;

    thumb_decode_top thumb_decode_top_i (
        .clk_i           (clk_i),
        .reset_i         (reset_i),
        .instr_i         (instr_i),
        .instr_valid_i   (instr_valid_i),
        .decoded_o       (decoded_o),
        .decoded_valid_o (decoded_valid_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #2 clk_i = ~clk_i;
    end

    task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("** Error: %s expected %h got %h at %0t", name, exp, act, $time);
        end
    endtask

    // valid strobe is passed straight through, so it must match on every cycle
    always @(negedge clk_i) begin
        check("decoded_valid_o", 32'(instr_valid_i), 32'(decoded_valid_o));
    end

    task automatic apply_reset();
        @(posedge clk_i);
        reset_i       <= 1'b1;
        instr_valid_i <= 1'b0;
        repeat (4) @(posedge clk_i);
        reset_i <= 1'b0;
    endtask

    // present one halfword, then sample at the falling edge
    task automatic drive(input instruction instr, input logic valid);
        int waited;
        @(posedge clk_i);
        instr_i       <= instr;
        instr_valid_i <= valid;
        @(negedge clk_i);
        waited = 0;
        while (decoded_valid_o !== valid && waited < 8) begin
            @(negedge clk_i);
            waited++;
        end
        if (decoded_valid_o !== valid) begin
            $display("timeout waiting for decoded_valid_o to follow instr_valid_i");
            errors++;
        end
    endtask

    task automatic check_decode(
        input instr_class  cls,
        input logic [3:0]  rd,
        input logic [3:0]  rn,
        input logic [3:0]  rm,
        input logic [31:0] imm,
        input logic        imm_valid,
        input logic        bl_complete,
        input logic        illegal
    );
        check("decoded_o.cls", 32'(cls), 32'(decoded_o.cls));
        check("decoded_o.rd", 32'(rd), 32'(decoded_o.rd));
        check("decoded_o.rn", 32'(rn), 32'(decoded_o.rn));
        check("decoded_o.rm", 32'(rm), 32'(decoded_o.rm));
        check("decoded_o.imm_valid", 32'(imm_valid), 32'(decoded_o.imm_valid));
        check("decoded_o.bl_complete", 32'(bl_complete), 32'(decoded_o.bl_complete));
        check("decoded_o.illegal", 32'(illegal), 32'(decoded_o.illegal));
        // immediate value only means something when flagged valid
        if (imm_valid) begin
            check("decoded_o.imm", imm, decoded_o.imm);
        end
    endtask

    // signed 11-bit prefix times 4096 plus suffix times 2
    function automatic logic [31:0] bl_offset(input logic [10:0] hi, input logic [10:0] lo);
        int v;
        v = int'(hi) * 4096 + int'(lo) * 2;
        if (hi[10]) begin
            v = v - 8388608;
        end
        return v;
    endfunction

    task automatic shift_and_arith();
        logic [31:0] r;
        logic [1:0]  op;
        repeat (8) begin
            r  = $random(seed);
            op = (r[12:11] == 2'b11) ? 2'b00 : r[12:11];
            drive({3'b000, op, r[10:6], r[5:3], r[2:0]}, 1'b1);
            check_decode(SHIFT_IMM, {1'b0, r[2:0]}, {1'b0, r[5:3]}, 4'd0,
                         32'(r[10:6]), 1'b1, 1'b0, 1'b0);
            // add/sub with a 3-bit immediate
            drive({5'b00011, 1'b1, r[13], r[8:6], r[5:3], r[2:0]}, 1'b1);
            check_decode(SHIFT_IMM, {1'b0, r[2:0]}, {1'b0, r[5:3]}, 4'd0,
                         32'(r[8:6]), 1'b1, 1'b0, 1'b0);
            // register form, second operand in rm
            drive({5'b00011, 1'b0, r[13], r[8:6], r[5:3], r[2:0]}, 1'b1);
            check_decode(SHIFT_IMM, {1'b0, r[2:0]}, {1'b0, r[5:3]}, {1'b0, r[8:6]},
                         32'd0, 1'b0, 1'b0, 1'b0);
            // mov has no first operand
            drive({3'b001, r[15:14], r[10:8], r[23:16]}, 1'b1);
            check_decode(ARITH_IMM8, {1'b0, r[10:8]},
                         (r[15:14] == 2'b00) ? 4'd0 : {1'b0, r[10:8]}, 4'd0,
                         32'(r[23:16]), 1'b1, 1'b0, 1'b0);
        end
    endtask

    task automatic load_store_offsets();
        logic [31:0] r;
        logic [3:0]  rd;
        logic [3:0]  rn;
        repeat (8) begin
            r  = $random(seed);
            rd = {1'b0, r[2:0]};
            rn = {1'b0, r[5:3]};
            drive({4'b0110, r[11], r[10:6], r[5:3], r[2:0]}, 1'b1);
            check_decode(LOAD_STORE_IMM, rd, rn, 4'd0, 32'(r[10:6]) * 32'd4,
                         1'b1, 1'b0, 1'b0);
            drive({4'b0111, r[11], r[10:6], r[5:3], r[2:0]}, 1'b1);
            check_decode(LOAD_STORE_BYTE, rd, rn, 4'd0, 32'(r[10:6]), 1'b1, 1'b0, 1'b0);
            drive({4'b1000, r[11], r[10:6], r[5:3], r[2:0]}, 1'b1);
            check_decode(LOAD_STORE_HW, rd, rn, 4'd0, 32'(r[10:6]) * 32'd2,
                         1'b1, 1'b0, 1'b0);
            // base is always the stack pointer
            drive({4'b1001, r[11], r[10:8], r[23:16]}, 1'b1);
            check_decode(LOAD_STORE_SP_R, {1'b0, r[10:8]}, 4'd13, 4'd0,
                         32'(r[23:16]) * 32'd4, 1'b1, 1'b0, 1'b0);
        end
    endtask

    task automatic misc_forms();
        logic [31:0] r;
        logic [3:0]  op;
        repeat (6) begin
            r = $random(seed);
            drive({8'b1011_0000, r[7], r[6:0]}, 1'b1);
            check_decode(MISC_SP_ADJ, 4'd13, 4'd13, 4'd0, 32'(r[6:0]) * 32'd4,
                         1'b1, 1'b0, 1'b0);
            // rsb carries an implied zero
            drive({6'b010000, 4'b1001, r[5:3], r[2:0]}, 1'b1);
            check_decode(DATA_PROCESSING, {1'b0, r[2:0]}, {1'b0, r[5:3]}, 4'd0,
                         32'd0, 1'b1, 1'b0, 1'b0);
            op = (r[11:8] == 4'b1001) ? 4'b0000 : r[11:8];
            drive({6'b010000, op, r[5:3], r[2:0]}, 1'b1);
            check_decode(DATA_PROCESSING, {1'b0, r[2:0]}, {1'b0, r[2:0]}, {1'b0, r[5:3]},
                         32'd0, 1'b0, 1'b0, 1'b0);
        end
    endtask

    task automatic bl_pair(input logic [10:0] hi, input logic [10:0] lo, input int gap);
        drive({5'b11110, hi}, 1'b1);
        check_decode(BL_PREFIX, 4'd0, 4'd0, 4'd0, 32'd0, 1'b0, 1'b0, 1'b0);
        repeat (gap) drive(instruction'($random(seed)), 1'b0);
        drive({5'b11111, lo}, 1'b1);
        check_decode(BL_SUFFIX, 4'd0, 4'd0, 4'd0, bl_offset(hi, lo), 1'b1, 1'b1, 1'b0);
    endtask

    task automatic bl_pairing();
        logic [31:0] r;
        bl_pair(11'h123, 11'h2aa, 0);
        bl_pair(11'h7f0, 11'h155, 0);
        bl_pair(11'h05a, 11'h7ff, 3);
        bl_pair(11'h400, 11'h001, 2);
        repeat (6) begin
            r = $random(seed);
            bl_pair(r[10:0], r[21:11], int'(r[23:22]));
        end
    endtask

    task automatic orphans_and_illegal();
        logic [31:0] r;
        logic [15:0] bases [0:8];
        bases = '{16'h4400, 16'h4800, 16'h5000, 16'ha000, 16'hb400,
                  16'hb800, 16'hc000, 16'hd000, 16'he000};
        r = $random(seed);
        // reset drops a pending prefix and clears the saved halfword
        drive({5'b11110, r[21:11]}, 1'b1);
        apply_reset();
        drive({5'b11111, r[10:0]}, 1'b1);
        check_decode(BL_SUFFIX, 4'd0, 4'd0, 4'd0, bl_offset(11'd0, r[10:0]),
                     1'b1, 1'b0, 1'b1);
        // prefix broken by an ordinary mov
        drive({5'b11110, r[21:11]}, 1'b1);
        drive({5'b00100, 3'd1, r[29:22]}, 1'b1);
        drive({5'b11111, r[10:0]}, 1'b1);
        check_decode(BL_SUFFIX, 4'd0, 4'd0, 4'd0, bl_offset({3'b001, r[29:22]}, r[10:0]),
                     1'b1, 1'b0, 1'b1);
        // second suffix after a completed pair
        bl_pair(r[21:11], r[10:0], 0);
        drive({5'b11111, r[21:11]}, 1'b1);
        check_decode(BL_SUFFIX, 4'd0, 4'd0, 4'd0, bl_offset(r[10:0], r[21:11]),
                     1'b1, 1'b0, 1'b1);
        foreach (bases[i]) begin
            r = $random(seed);
            drive(bases[i] | {8'h00, r[7:0]}, 1'b1);
            check_decode(ILLEGAL, 4'd0, 4'd0, 4'd0, 32'd0, 1'b0, 1'b0, 1'b1);
        end
    endtask

    initial begin
        reset_i       = 1'b1;
        instr_i       = '0;
        instr_valid_i = 1'b0;
        apply_reset();
        shift_and_arith();
        load_store_offsets();
        misc_forms();
        bl_pairing();
        orphans_and_illegal();
        drive('0, 1'b0);
        $display("checks: %0d  errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- all.f
verilog/thumb_decode_pkg.sv
verilog/instr_classify.sv
verilog/imm_gen.sv
verilog/reg_field_decode.sv
verilog/bl_pair_tracker.sv
verilog/thumb_decode_top.sv
tb/tb_thumb_decode.sv

//--- run_sim.sh
#!/bin/sh
# build and run the thumb decode testbench with Verilator

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

verilator --binary --timing --assert -j 0 --top-module tb_thumb_decode -f all.f -o sim_tb
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "NO ERRORS" sim.log; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed"
    exit 1
fi
